//--- source/floor_logic_pkg.sv
// Shared floor numbering for the request side of an eleven-floor car.
// Floor 0 is the lowest landing. Codes above top_floor are never produced
// by this logic, and inputs are expected to stay within range.

`default_nettype none

package floor_logic_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // Building size
    //////////////////////////////////////////////////////////////////////////////

    // Number of landings served
    localparam int floor_count = 11;

    //////////////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////////////

    // Binary floor number, 0 at the bottom
    typedef logic [3:0] floor_t;

    // One bit per landing, bit i is floor i
    typedef logic [floor_count-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////////////
    // Floor codes
    //////////////////////////////////////////////////////////////////////////////

    // Parking floor after reset
    localparam floor_t bottom_floor = 4'd0;

    // Highest legal floor code
    localparam floor_t top_floor = 4'd10;

endpackage

`default_nettype wire

//--- source/request_latch.sv
// Lamp register for one bank of floor buttons (hall calls or car panel).
// A press lights its lamp on the next clock and the lamp stays lit after
// release. A stop at a floor clears that floor's lamp. With power off or
// emergency held, every lamp holds its value.

`timescale 1ns/1ps
`default_nettype none

module request_latch (
    input  logic                        clock,
    input  logic                        reset_n,
    input  floor_logic_pkg::floor_mask_t buttons,
    input  logic                        power_switch,
    input  logic                        emergency_btn,
    input  logic                        car_moving,
    input  floor_logic_pkg::floor_t     current_floor,
    output floor_logic_pkg::floor_mask_t lights
);

    import floor_logic_pkg::*;

    //////////////////////////////////////////////////////////////////////////////
    // Service qualification
    //////////////////////////////////////////////////////////////////////////////

    logic service_en;

    // Normal service needs power and no emergency stop
    assign service_en = power_switch && !emergency_btn;

    //////////////////////////////////////////////////////////////////////////////
    // Per-floor lamps
    //////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < floor_count; i++) begin : g_lamp

        logic at_floor;
        logic stop_here;
        logic press;
        logic lamp_q;

        assign at_floor = (current_floor == floor_t'(i));

        // Car standing at this landing serves the request
        assign stop_here = !car_moving && at_floor;

        // A press at the car's own floor is ignored
        assign press = buttons[i] && !at_floor;

        always_ff @(posedge clock or negedge reset_n) begin
            if (!reset_n) begin
                lamp_q <= 1'b0;
            end else if (service_en) begin
                if (stop_here) begin
                    lamp_q <= 1'b0;
                end else if (press) begin
                    lamp_q <= 1'b1;
                end
            end
        end

        assign lights[i] = lamp_q;

    end

endmodule

`default_nettype wire

//--- source/target_select.sv
// Dispatch choice for the next target floor.
// The target reloads only while the car stands still at its present target,
// so a new request never redirects a car that is already on its way.
// Ties cannot occur, since each side has at most one nearest floor.
// With nothing pending the target becomes the current floor.

`timescale 1ns/1ps
`default_nettype none

module target_select (
    input  logic                        clock,
    input  logic                        reset_n,
    input  floor_logic_pkg::floor_mask_t call_lights,
    input  floor_logic_pkg::floor_mask_t panel_lights,
    input  floor_logic_pkg::floor_t     current_floor,
    input  logic                        car_moving,
    input  logic                        car_direction,
    output floor_logic_pkg::floor_t     target_floor
);

    import floor_logic_pkg::*;

    floor_mask_t pending;
    floor_t      nearest_up;
    floor_t      nearest_down;
    floor_t      next_target;
    logic        found_up;
    logic        found_down;
    logic        at_target;

    // A floor is pending if either its hall lamp or its panel lamp is lit
    assign pending = call_lights | panel_lights;

    //////////////////////////////////////////////////////////////////////////////
    // Nearest request on each side of the car
    //////////////////////////////////////////////////////////////////////////////

    // Scan from the top down, so the last hit is the closest one above
    always_comb begin
        found_up   = 1'b0;
        nearest_up = current_floor;
        for (int i = int'(top_floor); i >= 0; i--) begin
            if (pending[i] && (i > int'(current_floor))) begin
                found_up   = 1'b1;
                nearest_up = floor_t'(i);
            end
        end
    end

    // Scan from the bottom up, so the last hit is the closest one below
    always_comb begin
        found_down   = 1'b0;
        nearest_down = current_floor;
        for (int i = 0; i < floor_count; i++) begin
            if (pending[i] && (i < int'(current_floor))) begin
                found_down   = 1'b1;
                nearest_down = floor_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Direction preference
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (car_direction) begin
            // Travelling up: keep going up if anything waits above
            if (found_up) begin
                next_target = nearest_up;
            end else if (found_down) begin
                next_target = nearest_down;
            end else begin
                next_target = current_floor;
            end
        end else begin
            if (found_down) begin
                next_target = nearest_down;
            end else if (found_up) begin
                next_target = nearest_up;
            end else begin
                next_target = current_floor;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Target register
    //////////////////////////////////////////////////////////////////////////////

    assign at_target = !car_moving && (target_floor == current_floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= bottom_floor;
        end else if (at_target) begin
            target_floor <= next_target;
        end
    end

endmodule

`default_nettype wire

//--- source/motion_door_control.sv
// Move request and door permissions for the car FSM.
// All outputs are registered and so lag their inputs by one clock.
// The travel direction only changes when a move is requested and
// otherwise keeps its last value. Door gating ignores the emergency button.

`timescale 1ns/1ps
`default_nettype none

module motion_door_control (
    input  logic                    clock,
    input  logic                    reset_n,
    input  floor_logic_pkg::floor_t target_floor,
    input  floor_logic_pkg::floor_t current_floor,
    input  logic                    car_moving,
    input  logic                    power_switch,
    input  logic                    emergency_btn,
    input  logic                    door_open_btn,
    input  logic                    door_close_btn,
    output logic                    direction_selector,
    output logic                    activate_elevator,
    output logic                    door_open_allowed,
    output logic                    door_close_allowed
);

    import floor_logic_pkg::*;

    logic service_en;
    logic move_req;
    logic doors_ok;

    assign service_en = power_switch && !emergency_btn;

    // Stopped, in service, and somewhere else to go
    assign move_req = service_en && !car_moving
                      && (target_floor != current_floor);

    // Doors only operate with the car at rest and powered
    assign doors_ok = !car_moving && power_switch;

    //////////////////////////////////////////////////////////////////////////////
    // Move request and direction
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator  <= 1'b0;
            direction_selector <= 1'b1;
        end else begin
            activate_elevator <= move_req;
            if (move_req) begin
                direction_selector <= (target_floor > current_floor);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Door permissions
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && doors_ok;
            door_close_allowed <= door_close_btn && doors_ok;
        end
    end

endmodule

`default_nettype wire

//--- source/floor_logic_top.sv
// Request side of an eleven-floor elevator controller.
// Sits beside the car FSM, which supplies current_floor, car_moving and
// car_direction. A pressed button reaches activate_elevator three clocks
// later when the car is stopped. All inputs are assumed synchronous.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_top (
    input  logic                         clock,
    input  logic                         reset_n,
    input  floor_logic_pkg::floor_mask_t floor_call_buttons,
    input  floor_logic_pkg::floor_mask_t panel_buttons,
    input  logic                         door_open_btn,
    input  logic                         door_close_btn,
    input  logic                         emergency_btn,
    input  logic                         power_switch,
    input  floor_logic_pkg::floor_t      current_floor,
    input  logic                         car_moving,
    input  logic                         car_direction,
    output floor_logic_pkg::floor_mask_t call_button_lights,
    output floor_logic_pkg::floor_mask_t panel_button_lights,
    output floor_logic_pkg::floor_t      target_floor,
    output logic                         direction_selector,
    output logic                         activate_elevator,
    output logic                         door_open_allowed,
    output logic                         door_close_allowed
);

    import floor_logic_pkg::*;

    floor_mask_t call_lamps;
    floor_mask_t panel_lamps;
    floor_t      target;

    //////////////////////////////////////////////////////////////////////////////
    // Button decode into pending requests
    //////////////////////////////////////////////////////////////////////////////

    // Hall calls
    request_latch call_latch_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (floor_call_buttons),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .car_moving    (car_moving),
        .current_floor (current_floor),
        .lights        (call_lamps)
    );

    // Car panel destinations
    request_latch panel_latch_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (panel_buttons),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .car_moving    (car_moving),
        .current_floor (current_floor),
        .lights        (panel_lamps)
    );

    //////////////////////////////////////////////////////////////////////////////
    // Dispatch and car requests
    //////////////////////////////////////////////////////////////////////////////

    target_select target_select_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_lights   (call_lamps),
        .panel_lights  (panel_lamps),
        .current_floor (current_floor),
        .car_moving    (car_moving),
        .car_direction (car_direction),
        .target_floor  (target)
    );

    motion_door_control motion_door_control_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .target_floor       (target),
        .current_floor      (current_floor),
        .car_moving         (car_moving),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .direction_selector (direction_selector),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    // Lamp and target state for the landing indicators
    assign call_button_lights  = call_lamps;
    assign panel_button_lights = panel_lamps;
    assign target_floor        = target;

endmodule

`default_nettype wire

//--- test/floor_logic_tb.sv
// Testbench for floor_logic_top. A reference model built from the request,
// dispatch and door rules runs beside the DUT and is compared on every edge.
// Inputs change 0.5 ns after the rising edge. Stimulus uses an xorshift
// generator with a fixed seed, so every run is identical.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_tb;

    import floor_logic_pkg::*;

    localparam int stim_cycles = 4 + 20 + 3 + 10 + 10 + 22 + 300 + 33 + 2;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        car_moving;
    logic        car_direction;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      target_floor;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Reference model state
    floor_mask_t exp_call;
    floor_mask_t exp_panel;
    floor_t      exp_target;
    logic        exp_direction;
    logic        exp_activate;
    logic        exp_door_open;
    logic        exp_door_close;
    logic        service_on;
    logic [31:0] rng_state;

    floor_logic_top dut_i (.*);

    always #2 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic floor_mask_t next_lamps(floor_mask_t lamps, floor_mask_t btns,
                                               floor_t cur, logic moving, logic enabled);
        floor_mask_t result;
        result = lamps;
        if (enabled) begin
            for (int f = 0; f < floor_count; f++) begin
                if (int'(cur) == f) begin
                    if (!moving) result[f] = 1'b0;
                end else if (btns[f]) begin
                    result[f] = 1'b1;
                end
            end
        end
        return result;
    endfunction

    // Walk outward from the car one floor at a time
    function automatic floor_t pick_target(floor_mask_t pending, floor_t cur, logic up);
        int above;
        int below;
        above = -1;
        below = -1;
        for (int d = 1; d < floor_count; d++) begin
            if (above < 0 && int'(cur) + d < floor_count && pending[int'(cur) + d])
                above = int'(cur) + d;
            if (below < 0 && int'(cur) - d >= 0 && pending[int'(cur) - d])
                below = int'(cur) - d;
        end
        if (up && above >= 0) return floor_t'(above);
        if (!up && below >= 0) return floor_t'(below);
        if (above >= 0) return floor_t'(above);
        if (below >= 0) return floor_t'(below);
        return cur;
    endfunction

    assign service_on = power_switch && !emergency_btn;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_call       <= '0;
            exp_panel      <= '0;
            exp_target     <= bottom_floor;
            exp_direction  <= 1'b1;
            exp_activate   <= 1'b0;
            exp_door_open  <= 1'b0;
            exp_door_close <= 1'b0;
        end else begin
            exp_call  <= next_lamps(exp_call, floor_call_buttons, current_floor,
                                    car_moving, service_on);
            exp_panel <= next_lamps(exp_panel, panel_buttons, current_floor,
                                    car_moving, service_on);
            if (!car_moving && exp_target == current_floor)
                exp_target <= pick_target(exp_call | exp_panel, current_floor, car_direction);
            exp_activate <= service_on && !car_moving && exp_target != current_floor;
            if (service_on && !car_moving && exp_target != current_floor)
                exp_direction <= exp_target > current_floor;
            exp_door_open  <= door_open_btn && !car_moving && power_switch;
            exp_door_close <= door_close_btn && !car_moving && power_switch;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    assert property (@(posedge clock) disable iff (!reset_n) call_button_lights == exp_call)
        else report_mismatch("call_button_lights", 32'($sampled(exp_call)),
                             32'($sampled(call_button_lights)));
    assert property (@(posedge clock) disable iff (!reset_n) panel_button_lights == exp_panel)
        else report_mismatch("panel_button_lights", 32'($sampled(exp_panel)),
                             32'($sampled(panel_button_lights)));
    assert property (@(posedge clock) disable iff (!reset_n) target_floor == exp_target)
        else report_mismatch("target_floor", 32'($sampled(exp_target)),
                             32'($sampled(target_floor)));
    assert property (@(posedge clock) disable iff (!reset_n) activate_elevator == exp_activate)
        else report_mismatch("activate_elevator", 32'($sampled(exp_activate)),
                             32'($sampled(activate_elevator)));
    assert property (@(posedge clock) disable iff (!reset_n)
                     direction_selector == exp_direction)
        else report_mismatch("direction_selector", 32'($sampled(exp_direction)),
                             32'($sampled(direction_selector)));
    assert property (@(posedge clock) disable iff (!reset_n) door_open_allowed == exp_door_open)
        else report_mismatch("door_open_allowed", 32'($sampled(exp_door_open)),
                             32'($sampled(door_open_allowed)));
    assert property (@(posedge clock) disable iff (!reset_n)
                     door_close_allowed == exp_door_close)
        else report_mismatch("door_close_allowed", 32'($sampled(exp_door_close)),
                             32'($sampled(door_close_allowed)));

    // Values straight out of reset, independent of the model
    task automatic check_reset_values();
        assert (call_button_lights == '0)
            else report_mismatch("call_button_lights", 32'd0, 32'(call_button_lights));
        assert (panel_button_lights == '0)
            else report_mismatch("panel_button_lights", 32'd0, 32'(panel_button_lights));
        assert (target_floor == 4'd0)
            else report_mismatch("target_floor", 32'd0, 32'(target_floor));
        assert (direction_selector == 1'b1)
            else report_mismatch("direction_selector", 32'd1, 32'(direction_selector));
        assert (activate_elevator == 1'b0)
            else report_mismatch("activate_elevator", 32'd0, 32'(activate_elevator));
        assert (door_open_allowed == 1'b0 && door_close_allowed == 1'b0)
            else report_mismatch("door permissions", 32'd0,
                                 32'({door_open_allowed, door_close_allowed}));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic roll(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    // Sparse masks, about a quarter of the floors pressed
    task automatic press_random();
        logic [31:0] a;
        logic [31:0] b;
        roll(a);
        roll(b);
        floor_call_buttons = a[10:0] & a[21:11];
        panel_buttons      = b[10:0] & b[21:11];
    endtask

    task automatic random_floor();
        logic [31:0] r;
        roll(r);
        current_floor = floor_t'(r[15:0] % 16'd11);
    endtask

    // Mostly stopped and in service, often parked at the present target
    task automatic random_cycle();
        logic [31:0] r;
        press_random();
        roll(r);
        car_moving     = (r[2:0] == 3'd0);
        car_direction  = r[10];
        door_open_btn  = r[11];
        door_close_btn = r[12];
        power_switch   = (r[15:13] != 3'd0);
        emergency_btn  = (r[18:16] == 3'd0);
        if (r[4:3] != 2'd0)
            current_floor = exp_target;
        else
            current_floor = floor_t'(r[31:20] % 12'd11);
    endtask

    task automatic sweep_floors(int hold);
        floor_call_buttons = '0;
        panel_buttons      = '0;
        car_moving         = 1'b0;
        for (int f = 0; f < floor_count; f++) begin
            current_floor = floor_t'(f);
            repeat (hold) next_cycle();
        end
    endtask

    initial begin
        #(2 * stim_cycles * 4);
        $display("Watchdog expired: the stimulus did not complete in time");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = bottom_floor;
        car_moving         = 1'b1;
        car_direction      = 1'b1;
        rng_state          = 32'd26;

        repeat (4) next_cycle();
        reset_n = 1'b1;
        check_reset_values();

        // Latching while the car travels, then release
        repeat (20) begin
            press_random();
            random_floor();
            next_cycle();
        end
        floor_call_buttons = '0;
        panel_buttons      = '0;
        repeat (3) next_cycle();

        // Lamps frozen with power off, then with emergency held
        power_switch = 1'b0;
        repeat (10) begin
            press_random();
            random_floor();
            next_cycle();
        end
        power_switch  = 1'b1;
        emergency_btn = 1'b1;
        repeat (10) begin
            press_random();
            random_floor();
            next_cycle();
        end
        emergency_btn = 1'b0;

        // Stop at every landing to clear lit lamps
        sweep_floors(2);

        repeat (300) begin
            random_cycle();
            next_cycle();
        end

        // Nothing pending afterwards, so the target settles on the car
        power_switch   = 1'b1;
        emergency_btn  = 1'b0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        sweep_floors(3);
        repeat (2) next_cycle();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- floor_logic.f
source/floor_logic_pkg.sv
source/request_latch.sv
source/target_select.sv
source/motion_door_control.sv
source/floor_logic_top.sv
test/floor_logic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the floor logic testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message,
# or when the build or the simulation leaves no usable log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module floor_logic_tb \
    -f floor_logic.f -o floor_logic_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/floor_logic_sim > sim.log 2>&1
cat sim.log

[ -s sim.log ] || { echo "Simulation produced no output"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "Simulation reported failure"; exit 1; }

echo "Simulation finished without failure"
exit 0
